// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_load_queue
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= sim passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== common/lq_pkg.sv ====
`default_nettype none

package lq_pkg;

   parameter int LQ_DEPTH_DEF    = 24;     // queue entries
   parameter int ALLOC_WIDTH_DEF = 4;      // loads allocated per cycle

   parameter int TAG_W  = 7;               // reorder buffer load tag
   parameter int ADDR_W = 16;
   parameter int DATA_W = 16;
   parameter int PREG_W = 6;               // physical register number

   typedef logic [TAG_W-1:0]  lq_tag_t;
   typedef logic [ADDR_W-1:0] lq_addr_t;
   typedef logic [DATA_W-1:0] lq_data_t;
   typedef logic [PREG_W-1:0] lq_preg_t;

   // one rename slot, slots are filled from slot 0 upward
   typedef struct packed {
      logic    valid;
      lq_tag_t tag;
   } lq_alloc_slot_t;

   // result from the address unit
   typedef struct packed {
      logic     valid;
      lq_tag_t  tag;
      lq_addr_t addr;
      lq_preg_t preg;
   } lq_addr_upd_t;

   // store queue forwarding reply
   typedef struct packed {
      logic     ready;                     // pulses once per load
      logic     hit;                       // take the store data
      lq_data_t data;
   } lq_fwd_rsp_t;

   // register file writeback
   typedef struct packed {
      logic     valid;
      lq_tag_t  tag;
      lq_preg_t preg;
      lq_data_t data;
   } lq_wb_t;

   typedef enum logic [2:0] {
      IDLE      = 3'd0,                    // nothing to issue
      WAIT      = 3'd1,                    // request raised, waiting for grant
      ISSUED    = 3'd2,                    // granted, waiting for results
      MEM_RDY   = 3'd3,                    // cache data held, decision pending
      FWD_RDY   = 3'd4,                    // decision held, cache data pending
      BOTH_RDY  = 3'd5,                    // both results held
      WRITEBACK = 3'd6
   } lq_state_e;

endpackage

`default_nettype wire

// ==== filelist.f ====
common/lq_pkg.sv
load_queue/lq_entries.sv
load_queue/lq_select.sv
load_queue/lq_exec_fsm.sv
src/load_queue.sv
tests/lq_clock_gen.sv
tests/lq_checker.sv
tests/tb_load_queue.sv

// ==== load_queue/lq_entries.sv ====
`timescale 1ns/1ps
`default_nettype none

module lq_entries #(
   parameter int DEPTH       = 24,
   parameter int ALLOC_WIDTH = 4
) (
   input  wire                                          clk,
   input  wire                                          rst,
   input  wire lq_pkg::lq_alloc_slot_t [ALLOC_WIDTH-1:0] i_alloc,
   output logic                                         o_stall,
   input  wire lq_pkg::lq_addr_upd_t                    i_addr_upd,
   input  wire [$clog2(DEPTH)-1:0]                      i_cmmt_ptr,
   input  wire                                          i_flush,
   input  wire [$clog2(DEPTH)-1:0]                      i_flush_ptr,
   input  wire [$clog2(DEPTH)-1:0]                      i_cur_ptr,
   input  wire                                          i_finish,
   output logic [$clog2(DEPTH)-1:0]                     o_head,
   output logic [DEPTH-1:0]                             o_bid,
   output lq_pkg::lq_addr_t                             o_cur_addr,
   output lq_pkg::lq_tag_t                              o_cur_tag,
   output lq_pkg::lq_preg_t                             o_cur_preg
);

   import lq_pkg::*;

   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(ALLOC_WIDTH + 1);

   typedef logic [PTR_W-1:0] ptr_t;

   ptr_t             head;
   ptr_t             tail;                 // next free entry
   logic [DEPTH-1:0] ent_alloc;
   logic [DEPTH-1:0] ent_known;            // address and preg filled in
   logic [DEPTH-1:0] ent_done;
   lq_tag_t          ent_tag  [DEPTH];
   lq_addr_t         ent_addr [DEPTH];
   lq_preg_t         ent_preg [DEPTH];

   logic [CNT_W-1:0] alloc_cnt;
   logic [PTR_W:0]   used;
   logic             alloc_en;
   ptr_t             slot_ptr [ALLOC_WIDTH];
   ptr_t             cmmt_len;
   ptr_t             keep_len;             // entries that survive a flush
   logic [DEPTH-1:0] flush_clr;
   logic [DEPTH-1:0] cmmt_clr;
   logic [DEPTH-1:0] alloc_wr;
   logic [DEPTH-1:0] upd_hit;
   logic [DEPTH-1:0] fin_hit;
   lq_tag_t          alloc_tag [DEPTH];

   function automatic ptr_t ptr_add(ptr_t base, int unsigned off);
      int unsigned sum;
      sum = base + off;
      if (sum >= DEPTH) begin
         sum = sum - DEPTH;
      end
      return ptr_t'(sum);
   endfunction

   // distance walking forward from one pointer to another
   function automatic ptr_t ptr_dist(ptr_t from, ptr_t to);
      int unsigned d;
      if (to >= from) begin
         d = to - from;
      end else begin
         d = to + DEPTH - from;
      end
      return ptr_t'(d);
   endfunction

   always_comb begin
      alloc_cnt = '0;
      for (int k = 0; k < ALLOC_WIDTH; k++) begin
         alloc_cnt = alloc_cnt + CNT_W'(i_alloc[k].valid);
         slot_ptr[k] = ptr_add(tail, k);
      end
   end

   // head equal to tail means either empty or full
   assign used     = (head == tail && ent_alloc[head]) ? (PTR_W+1)'(DEPTH)
                                                       : {1'b0, ptr_dist(head, tail)};
   assign o_stall  = used > (PTR_W+1)'(DEPTH - ALLOC_WIDTH);
   assign alloc_en = !o_stall && !i_flush;

   always_comb begin
      cmmt_len = ptr_dist(head, i_cmmt_ptr);
      keep_len = ptr_dist(head, i_flush_ptr);
      for (int i = 0; i < DEPTH; i++) begin
         flush_clr[i] = i_flush && (ptr_dist(head, ptr_t'(i)) >= keep_len);
         cmmt_clr[i]  = ptr_dist(head, ptr_t'(i)) < cmmt_len;
         alloc_wr[i]  = 1'b0;
         alloc_tag[i] = '0;
         for (int k = 0; k < ALLOC_WIDTH; k++) begin
            if (alloc_en && i_alloc[k].valid && slot_ptr[k] == ptr_t'(i)) begin
               alloc_wr[i]  = 1'b1;
               alloc_tag[i] = i_alloc[k].tag;
            end
         end
         upd_hit[i] = i_addr_upd.valid && ent_alloc[i] && !flush_clr[i] &&
                      (ent_tag[i] == i_addr_upd.tag);
         fin_hit[i] = i_finish && (i_cur_ptr == ptr_t'(i));
         // the entry finishing now no longer bids
         o_bid[i]   = ent_alloc[i] && ent_known[i] && !ent_done[i] && !fin_hit[i];
      end
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         head      <= '0;
         tail      <= '0;
         ent_alloc <= '0;
         ent_known <= '0;
         ent_done  <= '0;
      end else begin
         head <= i_cmmt_ptr;
         if (i_flush) begin
            tail <= i_flush_ptr;
         end else if (alloc_en) begin
            tail <= ptr_add(tail, alloc_cnt);
         end
         for (int i = 0; i < DEPTH; i++) begin
            if (flush_clr[i] || cmmt_clr[i]) begin
               ent_alloc[i] <= 1'b0;
               ent_known[i] <= 1'b0;
               ent_done[i]  <= 1'b0;
            end else if (alloc_wr[i]) begin
               ent_alloc[i] <= 1'b1;
               ent_known[i] <= 1'b0;
               ent_done[i]  <= 1'b0;
            end else begin
               if (upd_hit[i]) begin
                  ent_known[i] <= 1'b1;
               end
               if (fin_hit[i]) begin
                  ent_done[i] <= 1'b1;
               end
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < DEPTH; i++) begin
         if (alloc_wr[i]) begin
            ent_tag[i] <= alloc_tag[i];
         end
         if (upd_hit[i]) begin
            ent_addr[i] <= i_addr_upd.addr;
            ent_preg[i] <= i_addr_upd.preg;
         end
      end
   end

   assign o_head     = head;
   assign o_cur_addr = ent_addr[i_cur_ptr];
   assign o_cur_tag  = ent_tag[i_cur_ptr];
   assign o_cur_preg = ent_preg[i_cur_ptr];

   // a stalled cycle must not bring in any new entry
   a_no_alloc_on_stall : assert property (@(posedge clk) disable iff (!rst)
      o_stall |=> (ent_alloc & ~$past(ent_alloc)) == '0);

endmodule

`default_nettype wire

// ==== load_queue/lq_exec_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module lq_exec_fsm (
   input  wire                       clk,
   input  wire                       rst,
   input  wire                       i_ld_rdy,
   input  wire                       i_flush,
   input  wire                       i_ld_grnt,
   input  wire                       i_mem_done,
   input  wire lq_pkg::lq_data_t     i_mem_data,
   input  wire lq_pkg::lq_fwd_rsp_t  i_fwd,
   input  wire lq_pkg::lq_tag_t      i_cur_tag,
   input  wire lq_pkg::lq_preg_t     i_cur_preg,
   output logic                      o_ld_req,
   output logic                      o_busy,
   output logic                      o_finish,
   output lq_pkg::lq_wb_t            o_wb
);

   import lq_pkg::*;

   lq_state_e state;
   lq_state_e nxt_state;
   lq_data_t  mem_data_q;
   lq_data_t  fwd_data_q;
   logic      fwd_hit_q;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         state <= IDLE;
      end else begin
         state <= nxt_state;
      end
   end

   always_comb begin
      nxt_state = state;
      if (i_flush) begin
         nxt_state = IDLE;                    // squash whatever is in flight
      end else begin
         case (state)
            IDLE: begin
               if (i_ld_rdy) begin
                  nxt_state = WAIT;
               end
            end
            WAIT: begin
               if (i_ld_grnt) begin
                  nxt_state = ISSUED;
               end
            end
            ISSUED: begin
               if (i_mem_done && i_fwd.ready) begin
                  nxt_state = BOTH_RDY;
               end else if (i_mem_done) begin
                  nxt_state = MEM_RDY;
               end else if (i_fwd.ready) begin
                  nxt_state = FWD_RDY;
               end
            end
            MEM_RDY: begin
               if (i_fwd.ready) begin
                  nxt_state = BOTH_RDY;
               end
            end
            FWD_RDY: begin
               if (i_mem_done) begin
                  nxt_state = BOTH_RDY;
               end
            end
            BOTH_RDY:  nxt_state = WRITEBACK;
            WRITEBACK: nxt_state = i_ld_rdy ? WAIT : IDLE;   // next load goes straight out
            default:   nxt_state = IDLE;
         endcase
      end
   end

   // results may come in either order
   always_ff @(posedge clk) begin
      if (i_mem_done) begin
         mem_data_q <= i_mem_data;
      end
      if (i_fwd.ready) begin
         fwd_hit_q  <= i_fwd.hit;
         fwd_data_q <= i_fwd.data;
      end
   end

   assign o_ld_req = state == WAIT;
   // pointer may move on during writeback
   assign o_busy   = !(state == IDLE || state == WRITEBACK);
   assign o_finish = state == WRITEBACK && !i_flush;

   always_comb begin
      o_wb.valid = o_finish;
      o_wb.tag   = i_cur_tag;
      o_wb.preg  = i_cur_preg;
      o_wb.data  = fwd_hit_q ? fwd_data_q : mem_data_q;
   end

   a_wb_single : assert property (@(posedge clk) disable iff (!rst)
      o_wb.valid |=> !o_wb.valid);

endmodule

`default_nettype wire

// ==== load_queue/lq_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module lq_select #(
   parameter int DEPTH = 24
) (
   input  wire                       clk,
   input  wire                       rst,
   input  wire [DEPTH-1:0]           i_bid,
   input  wire [$clog2(DEPTH)-1:0]   i_head,
   input  wire                       i_busy,
   output logic                      o_ld_rdy,
   output logic [$clog2(DEPTH)-1:0]  o_cur_ptr
);

   localparam int PTR_W = $clog2(DEPTH);

   logic [DEPTH-1:0] rot_bid;              // bit 0 is the head entry
   logic [PTR_W-1:0] sel_ptr;

   always_comb begin
      int unsigned idx;
      idx     = 0;
      sel_ptr = i_head;
      for (int k = 0; k < DEPTH; k++) begin
         idx = i_head + k;
         if (idx >= DEPTH) begin
            idx = idx - DEPTH;
         end
         rot_bid[k] = i_bid[idx];
      end
      // scan from the youngest so the oldest bidder wins
      for (int k = DEPTH - 1; k >= 0; k--) begin
         if (rot_bid[k]) begin
            idx = i_head + k;
            if (idx >= DEPTH) begin
               idx = idx - DEPTH;
            end
            sel_ptr = PTR_W'(idx);
         end
      end
   end

   assign o_ld_rdy = |i_bid;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         o_cur_ptr <= '0;
      end else if (!i_busy) begin
         o_cur_ptr <= sel_ptr;                // held while a load is in flight
      end
   end

   a_cur_was_bidding : assert property (@(posedge clk) disable iff (!rst)
      o_ld_rdy && !i_busy |=> ($past(i_bid) & (DEPTH'(1) << o_cur_ptr)) != '0);

endmodule

`default_nettype wire

// ==== src/load_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_queue #(
   parameter int DEPTH       = lq_pkg::LQ_DEPTH_DEF,
   parameter int ALLOC_WIDTH = lq_pkg::ALLOC_WIDTH_DEF
) (
   input  wire                                          clk,
   input  wire                                          rst,
   input  wire lq_pkg::lq_alloc_slot_t [ALLOC_WIDTH-1:0] i_alloc,
   output logic                                         o_stall,
   input  wire lq_pkg::lq_addr_upd_t                    i_addr_upd,
   output logic                                         o_ld_req,
   output lq_pkg::lq_addr_t                             o_addr,
   input  wire                                          i_ld_grnt,
   input  wire                                          i_mem_done,
   input  wire lq_pkg::lq_data_t                        i_mem_data,
   output lq_pkg::lq_tag_t                              o_fwd_tag,
   input  wire lq_pkg::lq_fwd_rsp_t                     i_fwd,
   output lq_pkg::lq_wb_t                               o_wb,
   input  wire [$clog2(DEPTH)-1:0]                      i_cmmt_ptr,
   input  wire                                          i_flush,
   input  wire [$clog2(DEPTH)-1:0]                      i_flush_ptr
);

   import lq_pkg::*;

   localparam int PTR_W = $clog2(DEPTH);

   logic [PTR_W-1:0] head;
   logic [PTR_W-1:0] cur_ptr;
   logic [DEPTH-1:0] bid;
   logic             ld_rdy;
   logic             busy;
   logic             finish;
   lq_tag_t          cur_tag;
   lq_preg_t         cur_preg;

   assign o_fwd_tag = cur_tag;               // store queue looks up the load in flight

   lq_entries #(
      .DEPTH       (DEPTH),
      .ALLOC_WIDTH (ALLOC_WIDTH)
   ) u_entries (
      .clk         (clk),
      .rst         (rst),
      .i_alloc     (i_alloc),
      .o_stall     (o_stall),
      .i_addr_upd  (i_addr_upd),
      .i_cmmt_ptr  (i_cmmt_ptr),
      .i_flush     (i_flush),
      .i_flush_ptr (i_flush_ptr),
      .i_cur_ptr   (cur_ptr),
      .i_finish    (finish),
      .o_head      (head),
      .o_bid       (bid),
      .o_cur_addr  (o_addr),
      .o_cur_tag   (cur_tag),
      .o_cur_preg  (cur_preg)
   );

   lq_select #(
      .DEPTH (DEPTH)
   ) u_select (
      .clk       (clk),
      .rst       (rst),
      .i_bid     (bid),
      .i_head    (head),
      .i_busy    (busy),
      .o_ld_rdy  (ld_rdy),
      .o_cur_ptr (cur_ptr)
   );

   lq_exec_fsm u_exec_fsm (
      .clk        (clk),
      .rst        (rst),
      .i_ld_rdy   (ld_rdy),
      .i_flush    (i_flush),
      .i_ld_grnt  (i_ld_grnt),
      .i_mem_done (i_mem_done),
      .i_mem_data (i_mem_data),
      .i_fwd      (i_fwd),
      .i_cur_tag  (cur_tag),
      .i_cur_preg (cur_preg),
      .o_ld_req   (o_ld_req),
      .o_busy     (busy),
      .o_finish   (finish),
      .o_wb       (o_wb)
   );

endmodule

`default_nettype wire

// ==== tests/lq_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module lq_checker (
   input  wire                 clk,
   input  wire                 rst,
   input  wire lq_pkg::lq_wb_t i_wb,
   input  wire                 i_stall,
   input  wire                 i_ld_req,
   input  wire lq_pkg::lq_addr_t i_addr,
   input  wire                 i_ld_grnt,
   input  wire                 i_flush
);

   import lq_pkg::*;

   lq_wb_t   exp_q [$];                    // writebacks still owed, oldest first
   int       wb_count     = 0;
   int       total_errs   = 0;
   int       errs_at_start = 0;
   int       tests_run    = 0;
   int       tests_failed = 0;
   logic     prev_req     = 1'b0;
   logic     prev_grnt    = 1'b0;
   logic     prev_flush   = 1'b0;
   lq_addr_t prev_addr    = '0;

   task automatic report_problem(input string msg);
      $display("ERROR: %s at %0t", msg, $time);
      total_errs++;
   endtask

   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] want);
      if (got !== want) begin
         $display("FAIL %s got %h expected %h at %0t", name, got, want, $time);
         total_errs++;
      end
   endtask

   task automatic expect_wb(input lq_tag_t tag, input lq_preg_t preg, input lq_data_t data);
      lq_wb_t e;
      e.valid = 1'b1;
      e.tag   = tag;
      e.preg  = preg;
      e.data  = data;
      exp_q.push_back(e);
   endtask

   task automatic check_stall(input logic want);
      compare_value("o_stall", 32'(i_stall), 32'(want));
   endtask

   task automatic check_reset_outputs();
      compare_value("o_ld_req", 32'(i_ld_req), 32'd0);
      compare_value("o_wb.valid", 32'(i_wb.valid), 32'd0);
      compare_value("o_stall", 32'(i_stall), 32'd0);
   endtask

   // values seen here are the ones held through the cycle that just ended
   always @(posedge clk) begin
      lq_wb_t e;
      if (rst) begin
         if (i_wb.valid) begin
            wb_count++;
            if (exp_q.size() == 0) begin
               report_problem("writeback arrived when no load was expected");
            end else begin
               e = exp_q.pop_front();
               compare_value("o_wb.tag", 32'(i_wb.tag), 32'(e.tag));
               compare_value("o_wb.preg", 32'(i_wb.preg), 32'(e.preg));
               compare_value("o_wb.data", 32'(i_wb.data), 32'(e.data));
            end
         end
         if (prev_req && !prev_grnt && !prev_flush) begin
            if (!i_ld_req) begin
               report_problem("load request dropped before grant");
            end else begin
               compare_value("o_addr", 32'(i_addr), 32'(prev_addr));
            end
         end
      end
      prev_req   = i_ld_req;
      prev_grnt  = i_ld_grnt;
      prev_flush = i_flush;
      prev_addr  = i_addr;
   end

   task automatic finish_test(input int num);
      if (exp_q.size() != 0) begin
         report_problem($sformatf("%0d writebacks never arrived", exp_q.size()));
         exp_q.delete();
      end
      tests_run++;
      if (total_errs == errs_at_start) begin
         $display("test %0d ok", num);
      end else begin
         $display("test %0d failed with %0d errors", num, total_errs - errs_at_start);
         tests_failed++;
      end
      errs_at_start = total_errs;
   endtask

   task automatic print_counts();
      $display("tests run %0d, tests failed %0d, errors %0d, writebacks %0d",
               tests_run, tests_failed, total_errs, wb_count);
   endtask

endmodule

`default_nettype wire

// ==== tests/lq_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module lq_clock_gen #(
   parameter int PERIOD_NS  = 100,
   parameter int RST_CYCLES = 16
) (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // release away from the rising edge
   initial begin
      rst = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      @(negedge clk);
      rst = 1'b1;
   end

endmodule

`default_nettype wire

// ==== tests/lq_patterns.txt ====
// num mode tag0 tag1 tag2 tag3 upd_order hit_mask st_base mem_base max_delay keep
// fwd_first_mask wb_order wb_data0 wb_data1 wb_data2 wb_data3 (mode 0 run, 1 stall, 2 flush)
0001 0000 0001 0002 0003 0004 3210 0000 5000 a000 0003 0000 0000 3012 a003 a000 a001 a002
0002 0000 0011 0012 0013 0014 0123 0005 5100 a100 0006 0000 0003 0123 5100 a101 5102 a103
0003 0000 0021 0022 0023 0024 2031 000a 5200 a200 000a 0000 000c 2013 a202 a200 5201 5203
0004 0001 0030 0031 0032 0033 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0005 0002 0041 0042 0043 0044 0123 0001 5400 a400 0004 0002 0005 0123 5400 a401 a402 a403
0006 0002 0051 0052 0053 0054 0123 000f 5500 a500 0005 0001 0009 0123 5500 5501 5502 5503
0007 0000 0061 0062 0063 0064 1302 0000 5600 a600 0002 0000 000f 1023 a601 a600 a602 a603

// ==== tests/tb_load_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_load_queue;

   import lq_pkg::*;

   localparam int DEPTH     = LQ_DEPTH_DEF;
   localparam int AW        = ALLOC_WIDTH_DEF;
   localparam int PTR_W     = $clog2(DEPTH);
   localparam int ROW_W     = 18;          // words per pattern row
   localparam int MAX_TESTS = 16;
   localparam int CYCLE_NS  = 100;

   logic                    clk;
   logic                    rst;
   lq_alloc_slot_t [AW-1:0] alloc;
   lq_addr_upd_t            addr_upd;
   logic                    stall;
   logic                    ld_req;
   lq_addr_t                addr;
   logic                    ld_grnt;
   logic                    mem_done;
   lq_data_t                mem_data;
   lq_tag_t                 fwd_tag;
   lq_fwd_rsp_t             fwd;
   lq_wb_t                  wb;
   logic [PTR_W-1:0]        cmmt_ptr;
   logic                    flush;
   logic [PTR_W-1:0]        flush_ptr;

   logic [15:0] pat [MAX_TESTS*ROW_W];
   int          n_tests = 0;
   integer      seed;
   int          tail;                      // next free entry as the testbench sees it
   lq_tag_t     row_tag [AW];
   logic [15:0] row_num, row_mode, row_order, row_hit, row_sbase, row_mbase;
   logic [15:0] row_maxd, row_keep, row_ffirst, row_exp_ord;
   logic [15:0] row_exp [AW];

   lq_clock_gen #(.PERIOD_NS(CYCLE_NS), .RST_CYCLES(16)) u_clock_gen (.clk(clk), .rst(rst));

   load_queue #(.DEPTH(DEPTH), .ALLOC_WIDTH(AW)) u_dut (
      .clk(clk), .rst(rst), .i_alloc(alloc), .o_stall(stall), .i_addr_upd(addr_upd),
      .o_ld_req(ld_req), .o_addr(addr), .i_ld_grnt(ld_grnt), .i_mem_done(mem_done),
      .i_mem_data(mem_data), .o_fwd_tag(fwd_tag), .i_fwd(fwd), .o_wb(wb),
      .i_cmmt_ptr(cmmt_ptr), .i_flush(flush), .i_flush_ptr(flush_ptr)
   );

   lq_checker u_checker (
      .clk(clk), .rst(rst), .i_wb(wb), .i_stall(stall), .i_ld_req(ld_req),
      .i_addr(addr), .i_ld_grnt(ld_grnt), .i_flush(flush)
   );

   function automatic lq_addr_t load_addr(input lq_tag_t tag);
      return {tag, 9'h155};
   endfunction

   function automatic lq_preg_t load_preg(input lq_tag_t tag);
      return tag[5:0] ^ 6'h2a;
   endfunction

   // called on a falling edge, returns on the next one with the slots cleared
   task automatic drive_alloc(input int first, input int count);
      for (int k = 0; k < AW; k++) begin
         alloc[k].valid = k < count;
         alloc[k].tag   = (k < count) ? row_tag[first+k] : '0;
      end
      @(negedge clk);
      alloc = '0;
   endtask

   task automatic update_addr(input int slot);
      addr_upd.valid = 1'b1;
      addr_upd.tag   = row_tag[slot];
      addr_upd.addr  = load_addr(row_tag[slot]);
      addr_upd.preg  = load_preg(row_tag[slot]);
      @(negedge clk);
      addr_upd.valid = 1'b0;
   endtask

   task automatic expect_row();
      int slot;
      for (int p = 0; p < AW; p++) begin
         slot = (row_exp_ord >> (12 - 4 * p)) & 4'hf;
         u_checker.expect_wb(row_tag[slot], load_preg(row_tag[slot]), row_exp[p]);
      end
   endtask

   task automatic drain_and_commit(input int goal);
      while (u_checker.wb_count < goal) @(negedge clk);
      repeat (4) @(negedge clk);
      cmmt_ptr = PTR_W'(tail);
      @(negedge clk);
   endtask

   task automatic run_normal();
      int goal;
      goal = u_checker.wb_count + AW;
      expect_row();
      u_checker.check_stall(1'b0);
      drive_alloc(0, AW);
      tail = (tail + AW) % DEPTH;
      for (int p = 0; p < AW; p++) begin
         update_addr((row_order >> (12 - 4 * p)) & 4'hf);
      end
      drain_and_commit(goal);
   endtask

   task automatic run_stall();
      int used;
      used = 0;
      for (int g = 0; g < DEPTH / AW; g++) begin
         u_checker.check_stall(used > DEPTH - AW);
         drive_alloc(0, AW);
         tail = (tail + AW) % DEPTH;
         used = used + AW;
      end
      u_checker.check_stall(used > DEPTH - AW);
      drive_alloc(0, AW);                     // dropped, the queue is full
      u_checker.check_stall(1'b1);
      cmmt_ptr = PTR_W'((tail + AW) % DEPTH);
      @(negedge clk);
      u_checker.check_stall(1'b0);
      cmmt_ptr = PTR_W'(tail);
      @(negedge clk);
      u_checker.check_stall(1'b0);
   endtask

   // flush while the load after the kept ones waits for grant, then reissue the rest
   task automatic run_flush();
      int goal;
      int base;
      int keep;
      goal = u_checker.wb_count + AW;
      base = tail;
      keep = int'(row_keep);
      expect_row();
      u_checker.check_stall(1'b0);
      drive_alloc(0, AW);
      tail = (tail + AW) % DEPTH;
      for (int p = 0; p < AW; p++) begin
         update_addr((row_order >> (12 - 4 * p)) & 4'hf);
      end
      while (!(u_checker.wb_count == goal - AW + keep && ld_req)) @(negedge clk);
      flush     = 1'b1;
      flush_ptr = PTR_W'((base + keep) % DEPTH);
      @(negedge clk);
      flush = 1'b0;
      tail  = (base + keep) % DEPTH;
      drive_alloc(keep, AW - keep);
      tail = (tail + AW - keep) % DEPTH;
      for (int s = keep; s < AW; s++) begin
         update_addr(s);
      end
      drain_and_commit(goal);
   endtask

   task automatic load_row(input int t);
      int b;
      b           = t * ROW_W;
      row_num     = pat[b];
      row_mode    = pat[b+1];
      row_order   = pat[b+6];
      row_hit     = pat[b+7];
      row_sbase   = pat[b+8];
      row_mbase   = pat[b+9];
      row_maxd    = pat[b+10];
      row_keep    = pat[b+11];
      row_ffirst  = pat[b+12];
      row_exp_ord = pat[b+13];
      for (int k = 0; k < AW; k++) begin
         row_tag[k] = pat[b+2+k][TAG_W-1:0];
         row_exp[k] = pat[b+14+k];
      end
   endtask

   // arbiter, cache and store queue
   initial begin
      int       delay;
      int       idx;
      logic     lost;
      lq_addr_t cap_addr;
      ld_grnt  = 1'b0;
      mem_done = 1'b0;
      mem_data = '0;
      fwd      = '0;
      forever begin
         @(negedge clk);
         if (rst && ld_req) begin
            delay = 1 + int'($unsigned($random(seed)) % (32'(row_maxd) + 1));
            lost  = 1'b0;
            while (delay > 0 && !lost) begin
               @(negedge clk);
               if (!ld_req) lost = 1'b1;
               else delay--;
            end
            if (!lost) begin
               ld_grnt  = 1'b1;
               cap_addr = addr;
               @(negedge clk);
               ld_grnt = 1'b0;
               idx     = -1;
               for (int k = 0; k < AW; k++) begin
                  if (load_addr(row_tag[k]) == cap_addr) idx = k;
               end
               if (idx < 0) begin
                  u_checker.report_problem("memory read to an address of no known load");
               end else begin
                  for (int step = 0; step < 2; step++) begin
                     if ((step == 0) == row_ffirst[idx]) begin
                        // store queue looks the load up by its tag
                        u_checker.compare_value("o_fwd_tag", 32'(fwd_tag),
                                                32'(row_tag[idx]));
                        fwd.ready = 1'b1;
                        fwd.hit   = row_hit[idx];
                        fwd.data  = row_sbase + 16'(idx);
                     end else begin
                        mem_done = 1'b1;
                        mem_data = row_mbase + 16'(idx);
                     end
                     @(negedge clk);
                     fwd.ready = 1'b0;
                     mem_done  = 1'b0;
                  end
               end
            end
         end
      end
   end

   initial begin
      alloc     = '0;
      addr_upd  = '0;
      cmmt_ptr  = '0;
      flush     = 1'b0;
      flush_ptr = '0;
      tail      = 0;
      seed      = 32'h1308_977c;
      for (int i = 0; i < MAX_TESTS * ROW_W; i++) pat[i] = 16'hffff;
      $readmemh("tests/lq_patterns.txt", pat);
      for (int t = 0; t < MAX_TESTS; t++) begin
         if (pat[t*ROW_W] != 16'hffff) n_tests = t + 1;
      end
      @(posedge rst);
      @(negedge clk);
      u_checker.check_reset_outputs();
      if (n_tests == 0) u_checker.report_problem("no tests found in the pattern file");
      for (int t = 0; t < n_tests; t++) begin
         load_row(t);
         case (row_mode)
            16'd1:   run_stall();
            16'd2:   run_flush();
            default: run_normal();
         endcase
         u_checker.finish_test(int'(row_num));
      end
      u_checker.print_counts();
      if (u_checker.total_errs == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

   initial begin
      wait (n_tests > 0);
      #(n_tests * 400 * CYCLE_NS);
      $display("ERROR: watchdog expired after %0d cycles", n_tests * 400);
      $display("sim failed");
      $finish;
   end

endmodule

`default_nettype wire
